//--- adaptive_bin.f
hw/adaptive_bin_pkg.sv
hw/window_fetch.sv
hw/box_sum.sv
hw/threshold_out.sv
hw/adaptive_bin_top.sv
verification/adaptive_bin_tb.sv

//--- hw/adaptive_bin_pkg.sv
package adaptive_bin_pkg;

  localparam int COLS = 11;  // Image width in pixels
  localparam int ROWS = 11;
  localparam int WIN_SIZE = 3;  // Square window edge
  localparam int WIN_COLS_MAX = COLS - WIN_SIZE + 1;
  localparam int HIST_LEN = 4;  // Window sums per region
  localparam int POS_DEPTH = 8;

  typedef logic [7:0] pixel_t;
  typedef logic [3:0] coord_t;
  typedef logic [8:0] pair_sum_t;
  typedef logic [9:0] quad_sum_t;
  typedef logic [10:0] oct_sum_t;
  typedef logic [11:0] win_sum_t;  // Nine pixels
  typedef logic [13:0] region_sum_t;  // Up to HIST_LEN window sums
  typedef logic [2:0] nterms_t;

  // Row-major, p4 is the centre
  typedef struct packed {
    pixel_t p0;
    pixel_t p1;
    pixel_t p2;
    pixel_t p3;
    pixel_t p4;
    pixel_t p5;
    pixel_t p6;
    pixel_t p7;
    pixel_t p8;
  } window_t;

  typedef struct packed {
    logic    valid;
    logic    first;  // Leftmost window of its row
    window_t win;
  } win_item_t;

  typedef struct packed {
    logic        valid;
    region_sum_t region;
    nterms_t     nterms;
    pixel_t      centre;
  } sum_item_t;

  typedef struct packed {
    coord_t col;
    coord_t row;
  } pos_t;

endpackage

//--- hw/adaptive_bin_top.sv
module adaptive_bin_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     i_frame_start,
  input  logic                     i_pix_valid,
  input  adaptive_bin_pkg::pixel_t i_pix,
  output logic                     o_res_valid,
  output logic                     o_res_bin,
  output adaptive_bin_pkg::coord_t o_res_col,
  output adaptive_bin_pkg::coord_t o_res_row
);

  adaptive_bin_pkg::win_item_t win_item;
  adaptive_bin_pkg::sum_item_t sum_item;
  adaptive_bin_pkg::coord_t    win_col;
  adaptive_bin_pkg::coord_t    win_row;

  window_fetch u_fetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_frame_start (i_frame_start),
    .i_pix_valid   (i_pix_valid),
    .i_pix         (i_pix),
    .o_item        (win_item),
    .o_col         (win_col),
    .o_row         (win_row)
  );

  box_sum u_sum (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_item (win_item),
    .o_item (sum_item)
  );

  threshold_out u_thresh (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_item      (sum_item),
    .i_pos_wr    (win_item.valid),  // Position written as the window leaves decode
    .i_col       (win_col),
    .i_row       (win_row),
    .o_res_valid (o_res_valid),
    .o_res_bin   (o_res_bin),
    .o_res_col   (o_res_col),
    .o_res_row   (o_res_row)
  );

endmodule

//--- hw/box_sum.sv
module box_sum (
  input  logic                        clk,
  input  logic                        rst_n,
  input  adaptive_bin_pkg::win_item_t i_item,
  output adaptive_bin_pkg::sum_item_t o_item
);

  adaptive_bin_pkg::pair_sum_t   pair_q [4];
  adaptive_bin_pkg::quad_sum_t   quad_q [2];
  adaptive_bin_pkg::oct_sum_t    oct_q;
  adaptive_bin_pkg::win_sum_t    win_sum_q;
  adaptive_bin_pkg::pixel_t      p8_q [3];  // Ninth pixel waits for the tree
  adaptive_bin_pkg::pixel_t      centre_q [5];
  adaptive_bin_pkg::win_sum_t    hist_q [adaptive_bin_pkg::HIST_LEN];
  adaptive_bin_pkg::region_sum_t region_q;
  adaptive_bin_pkg::region_sum_t drop_sum;
  adaptive_bin_pkg::nterms_t     nterms_q;
  logic [3:0] valid_q;
  logic [3:0] first_q;
  logic       out_valid;

  // Four registered levels, p8 joins at the last
  always_ff @(posedge clk) begin
    pair_q[0] <= adaptive_bin_pkg::pair_sum_t'(i_item.win.p0) +
                 adaptive_bin_pkg::pair_sum_t'(i_item.win.p1);
    pair_q[1] <= adaptive_bin_pkg::pair_sum_t'(i_item.win.p2) +
                 adaptive_bin_pkg::pair_sum_t'(i_item.win.p3);
    pair_q[2] <= adaptive_bin_pkg::pair_sum_t'(i_item.win.p4) +
                 adaptive_bin_pkg::pair_sum_t'(i_item.win.p5);
    pair_q[3] <= adaptive_bin_pkg::pair_sum_t'(i_item.win.p6) +
                 adaptive_bin_pkg::pair_sum_t'(i_item.win.p7);
    quad_q[0] <= adaptive_bin_pkg::quad_sum_t'(pair_q[0]) +
                 adaptive_bin_pkg::quad_sum_t'(pair_q[1]);
    quad_q[1] <= adaptive_bin_pkg::quad_sum_t'(pair_q[2]) +
                 adaptive_bin_pkg::quad_sum_t'(pair_q[3]);
    oct_q     <= adaptive_bin_pkg::oct_sum_t'(quad_q[0]) +
                 adaptive_bin_pkg::oct_sum_t'(quad_q[1]);
    win_sum_q <= adaptive_bin_pkg::win_sum_t'(oct_q) +
                 adaptive_bin_pkg::win_sum_t'(p8_q[2]);
    p8_q[0] <= i_item.win.p8;
    p8_q[1] <= p8_q[0];
    p8_q[2] <= p8_q[1];
    centre_q[0] <= i_item.win.p4;
    for (int i = 0; i < 4; i++) begin
      centre_q[i+1] <= centre_q[i];
    end
    first_q <= {first_q[2:0], i_item.first};
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q   <= '0;
      out_valid <= 1'b0;
    end else begin
      valid_q   <= {valid_q[2:0], i_item.valid};
      out_valid <= valid_q[3];
    end
  end

  // Oldest sum leaves once the region holds HIST_LEN terms
  assign drop_sum = (nterms_q == adaptive_bin_pkg::HIST_LEN) ?
                    adaptive_bin_pkg::region_sum_t'(hist_q[adaptive_bin_pkg::HIST_LEN-1]) :
                    '0;

  always_ff @(posedge clk) begin
    if (valid_q[3]) begin
      hist_q[0] <= win_sum_q;
      for (int i = 0; i < adaptive_bin_pkg::HIST_LEN - 1; i++) begin
        hist_q[i+1] <= hist_q[i];
      end
      if (first_q[3]) begin
        region_q <= adaptive_bin_pkg::region_sum_t'(win_sum_q);  // New row
      end else begin
        region_q <= region_q + adaptive_bin_pkg::region_sum_t'(win_sum_q) - drop_sum;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      nterms_q <= '0;
    end else if (valid_q[3]) begin
      if (first_q[3]) begin
        nterms_q <= adaptive_bin_pkg::nterms_t'(1);
      end else if (nterms_q != adaptive_bin_pkg::HIST_LEN) begin
        nterms_q <= nterms_q + 1'b1;
      end
    end
  end

  assign o_item.valid  = out_valid;
  assign o_item.region = region_q;
  assign o_item.nterms = nterms_q;
  assign o_item.centre = centre_q[4];

  a_nterms_range: assert property (@(posedge clk) disable iff (!rst_n)
    o_item.valid |-> (o_item.nterms inside {[1:adaptive_bin_pkg::HIST_LEN]}))
    else $error("box_sum term count out of range: %0d", o_item.nterms);

endmodule

//--- hw/threshold_out.sv
module threshold_out (
  input  logic                        clk,
  input  logic                        rst_n,
  input  adaptive_bin_pkg::sum_item_t i_item,
  input  logic                        i_pos_wr,
  input  adaptive_bin_pkg::coord_t    i_col,
  input  adaptive_bin_pkg::coord_t    i_row,
  output logic                        o_res_valid,
  output logic                        o_res_bin,
  output adaptive_bin_pkg::coord_t    o_res_col,
  output adaptive_bin_pkg::coord_t    o_res_row
);

  adaptive_bin_pkg::pos_t pos_mem [adaptive_bin_pkg::POS_DEPTH];
  logic [$clog2(adaptive_bin_pkg::POS_DEPTH)-1:0] wr_ptr;
  logic [$clog2(adaptive_bin_pkg::POS_DEPTH)-1:0] rd_ptr;
  logic [$clog2(adaptive_bin_pkg::POS_DEPTH):0]   pos_count;
  adaptive_bin_pkg::region_sum_t scaled;

  // Centre times window area times terms, against the region sum
  assign scaled = adaptive_bin_pkg::region_sum_t'(i_item.centre) *
                  adaptive_bin_pkg::region_sum_t'(adaptive_bin_pkg::WIN_SIZE *
                                                  adaptive_bin_pkg::WIN_SIZE) *
                  adaptive_bin_pkg::region_sum_t'(i_item.nterms);

  always_ff @(posedge clk) begin
    if (i_pos_wr) begin
      pos_mem[wr_ptr] <= '{col: i_col, row: i_row};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      pos_count   <= '0;
      o_res_valid <= 1'b0;
    end else begin
      if (i_pos_wr) wr_ptr <= wr_ptr + 1'b1;
      if (i_item.valid) rd_ptr <= rd_ptr + 1'b1;
      case ({i_pos_wr, i_item.valid})
        2'b10:   pos_count <= pos_count + 1'b1;
        2'b01:   pos_count <= pos_count - 1'b1;
        default: pos_count <= pos_count;
      endcase
      o_res_valid <= i_item.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_item.valid) begin
      o_res_bin <= (scaled > i_item.region);  // Brighter than local mean
      o_res_col <= pos_mem[rd_ptr].col;
      o_res_row <= pos_mem[rd_ptr].row;
    end
  end

  a_pos_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    i_item.valid |-> (pos_count != 0))
    else $error("threshold_out position FIFO underflow");

endmodule

//--- hw/window_fetch.sv
module window_fetch (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        i_frame_start,
  input  logic                        i_pix_valid,
  input  adaptive_bin_pkg::pixel_t    i_pix,
  output adaptive_bin_pkg::win_item_t o_item,
  output adaptive_bin_pkg::coord_t    o_col,
  output adaptive_bin_pkg::coord_t    o_row
);

  adaptive_bin_pkg::coord_t col;
  adaptive_bin_pkg::coord_t row;
  adaptive_bin_pkg::pixel_t line0 [adaptive_bin_pkg::COLS];  // Row above
  adaptive_bin_pkg::pixel_t line1 [adaptive_bin_pkg::COLS];  // Two rows above
  adaptive_bin_pkg::pixel_t top_sr [adaptive_bin_pkg::WIN_SIZE];
  adaptive_bin_pkg::pixel_t mid_sr [adaptive_bin_pkg::WIN_SIZE];
  adaptive_bin_pkg::pixel_t bot_sr [adaptive_bin_pkg::WIN_SIZE];
  logic item_valid;
  logic item_first;
  logic col_last;
  logic win_full;

  assign col_last = (col == adaptive_bin_pkg::COLS - 1);
  assign win_full = (col >= adaptive_bin_pkg::WIN_SIZE - 1) &&
                    (row >= adaptive_bin_pkg::WIN_SIZE - 1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col <= '0;
      row <= '0;
    end else if (i_frame_start) begin
      col <= '0;
      row <= '0;
    end else if (i_pix_valid) begin
      if (col_last) begin
        col <= '0;
        row <= (row == adaptive_bin_pkg::ROWS - 1) ? '0 : row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // Line buffers and the window columns shift together
  always_ff @(posedge clk) begin
    if (i_pix_valid) begin
      line1[col] <= line0[col];
      line0[col] <= i_pix;
      for (int i = 0; i < adaptive_bin_pkg::WIN_SIZE - 1; i++) begin
        top_sr[i] <= top_sr[i+1];
        mid_sr[i] <= mid_sr[i+1];
        bot_sr[i] <= bot_sr[i+1];
      end
      top_sr[adaptive_bin_pkg::WIN_SIZE-1] <= line1[col];
      mid_sr[adaptive_bin_pkg::WIN_SIZE-1] <= line0[col];
      bot_sr[adaptive_bin_pkg::WIN_SIZE-1] <= i_pix;  // Live pixel
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      item_valid <= 1'b0;
    end else begin
      item_valid <= i_pix_valid && win_full;
    end
  end

  always_ff @(posedge clk) begin
    if (i_pix_valid) begin
      item_first <= (col == adaptive_bin_pkg::COLS - adaptive_bin_pkg::WIN_COLS_MAX);
      o_col      <= col - adaptive_bin_pkg::coord_t'(adaptive_bin_pkg::WIN_SIZE - 1);
      o_row      <= row - adaptive_bin_pkg::coord_t'(adaptive_bin_pkg::WIN_SIZE - 1);
    end
  end

  assign o_item.valid = item_valid;
  assign o_item.first = item_first;
  assign o_item.win = {top_sr[0], top_sr[1], top_sr[2],
                       mid_sr[0], mid_sr[1], mid_sr[2],
                       bot_sr[0], bot_sr[1], bot_sr[2]};

  a_col_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    col < adaptive_bin_pkg::COLS)
    else $error("window_fetch column count out of range: %0d", col);

endmodule

//--- run_sim.sh
#!/bin/sh
LOG=sim.log
verilator --binary --timing -Wno-fatal --top-module adaptive_bin_tb \
  -f adaptive_bin.f -o sim_adaptive_bin > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_adaptive_bin > "$LOG" 2>&1
cat "$LOG"
grep -q "SOME TESTS FAILED" "$LOG" && { echo "Simulation failed, see $LOG"; exit 1; }
grep -q "ALL TESTS PASSED" "$LOG" || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"

//--- verification/adaptive_bin_patterns.txt
// Per image: 121 pixels (11 rows of 11, raster order), then 81 expected bits
// (9 rows of 9, raster window order); bit is 1 when centre*9*terms > region sum
// Image 0: horizontal gradient, pixel = 20*col + 3*row + 5
05 19 2D 41 55 69 7D 91 A5 B9 CD
08 1C 30 44 58 6C 80 94 A8 BC D0
0B 1F 33 47 5B 6F 83 97 AB BF D3
0E 22 36 4A 5E 72 86 9A AE C2 D6
11 25 39 4D 61 75 89 9D B1 C5 D9
14 28 3C 50 64 78 8C A0 B4 C8 DC
17 2B 3F 53 67 7B 8F A3 B7 CB DF
1A 2E 42 56 6A 7E 92 A6 BA CE E2
1D 31 45 59 6D 81 95 A9 BD D1 E5
20 34 48 5C 70 84 98 AC C0 D4 E8
23 37 4B 5F 73 87 9B AF C3 D7 EB
0 1 1 1 1 1 1 1 1
0 1 1 1 1 1 1 1 1
0 1 1 1 1 1 1 1 1
0 1 1 1 1 1 1 1 1
0 1 1 1 1 1 1 1 1
0 1 1 1 1 1 1 1 1
0 1 1 1 1 1 1 1 1
0 1 1 1 1 1 1 1 1
0 1 1 1 1 1 1 1 1
// Image 1: random separable image, pixel = f(col) + g(row)
7F CA 5F B2 96 68 BD A1 71 D0 88
31 7C 11 64 48 1A 6F 53 23 82 3A
68 B3 48 9B 7F 51 A6 8A 5A B9 71
8A D5 6A BD A1 73 C8 AC 7C DB 93
28 73 08 5B 3F 11 66 4A 1A 79 31
5C A7 3C 8F 73 45 9A 7E 4E AD 65
9D E8 7D D0 B4 86 DB BF 8F EE A6
41 8C 21 74 58 2A 7F 63 33 92 4A
74 BF 54 A7 8B 5D B2 96 66 C5 7D
4D 98 2D 80 64 36 8B 6F 3F 9E 56
2D 78 0D 60 44 16 6B 4F 1F 7E 36
1 0 0 0 0 0 0 0 1
1 0 1 1 0 1 1 0 1
1 0 1 1 1 1 1 1 1
1 0 0 0 0 0 0 0 1
1 0 1 0 0 1 1 0 1
1 0 1 1 1 1 1 1 1
1 0 0 0 0 0 0 0 1
1 0 1 1 0 1 1 0 1
1 0 1 1 0 1 1 0 1

//--- verification/adaptive_bin_tb.sv
module adaptive_bin_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_IMAGES = 2;
  localparam int IMG_PIX = adaptive_bin_pkg::COLS * adaptive_bin_pkg::ROWS;
  localparam int WIN_ROWS = adaptive_bin_pkg::ROWS - adaptive_bin_pkg::WIN_SIZE + 1;
  localparam int IMG_RES = adaptive_bin_pkg::WIN_COLS_MAX * WIN_ROWS;
  localparam int IMG_WORDS = IMG_PIX + IMG_RES;
  localparam int LATENCY = 7;
  localparam int STRAY_PIX = 3;  // Aborted frame, fewer than one window
  localparam int WATCHDOG_CYCLES = (NUM_IMAGES * IMG_PIX + STRAY_PIX) * 5 + 200;

  typedef struct packed {
    logic [31:0]              cycle;  // Cycle of the completing pixel strobe
    logic                     img;
    adaptive_bin_pkg::coord_t col;
    adaptive_bin_pkg::coord_t row;
    logic                     bin;
  } expect_t;

  logic                     clk;
  logic                     rst_n;
  logic                     frame_start;
  logic                     pix_valid;
  adaptive_bin_pkg::pixel_t pix;
  logic                     res_valid;
  logic                     res_bin;
  adaptive_bin_pkg::coord_t res_col;
  adaptive_bin_pkg::coord_t res_row;

  logic [7:0]  pat_mem [NUM_IMAGES * IMG_WORDS];
  expect_t     exp_q [$];
  logic [31:0] cycle_cnt = '0;
  logic [31:0] lcg_state;
  int          value_errors;
  int          flow_errors;
  int          img_count [NUM_IMAGES];

  adaptive_bin_top uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_frame_start (frame_start),
    .i_pix_valid   (pix_valid),
    .i_pix         (pix),
    .o_res_valid   (res_valid),
    .o_res_bin     (res_bin),
    .o_res_col     (res_col),
    .o_res_row     (res_row)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_bin(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("FAIL %s got %h expected %h", name, got, expected);
      value_errors++;
    end
  endtask

  task automatic check_coord(input string name, input adaptive_bin_pkg::coord_t got,
                             input adaptive_bin_pkg::coord_t expected);
    if (got !== expected) begin
      $display("FAIL %s got %h expected %h", name, got, expected);
      value_errors++;
    end
  endtask

  task automatic check_latency(input int got, input int expected);
    if (got != expected) begin
      $display("FAIL latency got %h expected %h", got, expected);
      value_errors++;
    end
  endtask

  task automatic step_idle();
    @(posedge clk);
    #1;
    pix_valid = 1'b0;
    frame_start = 1'b0;
  endtask

  task automatic pulse_frame_start();
    @(posedge clk);
    #1;
    pix_valid = 1'b0;
    frame_start = 1'b1;
    step_idle();
  endtask

  // Pixels of an abandoned frame, leaving the counters mid-row
  task automatic drive_stray_pixels(input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge clk);
      #1;
      pix_valid = 1'b1;
      pix = 8'hFF;
    end
  endtask

  // One pixel strobe, queueing the result of the window it completes
  task automatic drive_pixel(input int img, input int col, input int row);
    expect_t item;
    @(posedge clk);
    #1;
    pix_valid = 1'b1;
    pix = pat_mem[img * IMG_WORDS + row * adaptive_bin_pkg::COLS + col];
    if (col >= 2 && row >= 2) begin
      item.cycle = cycle_cnt;
      item.img = img[0];
      item.col = adaptive_bin_pkg::coord_t'(col - 2);
      item.row = adaptive_bin_pkg::coord_t'(row - 2);
      item.bin = pat_mem[img * IMG_WORDS + IMG_PIX +
                         (row - 2) * adaptive_bin_pkg::WIN_COLS_MAX + (col - 2)][0];
      exp_q.push_back(item);
    end
  endtask

  always @(negedge clk) begin
    expect_t head;
    if (!rst_n) begin
      if (res_valid) begin
        $display("Result strobe seen while reset is asserted");
        flow_errors++;
      end
    end else if (res_valid) begin
      if (exp_q.size() == 0) begin
        $display("Extra result at window (%0d,%0d) with no window pending", res_col, res_row);
        flow_errors++;
      end else begin
        head = exp_q.pop_front();
        check_bin("o_res_bin", res_bin, head.bin);
        check_coord("o_res_col", res_col, head.col);
        check_coord("o_res_row", res_row, head.row);
        check_latency(int'(cycle_cnt - head.cycle), LATENCY);
        img_count[head.img]++;
      end
    end else if (exp_q.size() != 0 && cycle_cnt - exp_q[0].cycle > LATENCY + 4) begin
      $display("Missing result for window (%0d,%0d)", exp_q[0].col, exp_q[0].row);
      flow_errors++;
      void'(exp_q.pop_front());
    end
  end

  initial begin
    int gap;
    rst_n = 1'b0;
    frame_start = 1'b0;
    pix_valid = 1'b0;
    pix = '0;
    value_errors = 0;
    flow_errors = 0;
    foreach (img_count[i]) img_count[i] = 0;
    lcg_state = 32'h34066285;
    $readmemh("verification/adaptive_bin_patterns.txt", pat_mem);
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int img = 0; img < NUM_IMAGES; img++) begin
      if (img > 0) begin
        drive_stray_pixels(STRAY_PIX);
      end
      pulse_frame_start();  // Second pulse lands while image 0 windows are in flight
      for (int row = 0; row < adaptive_bin_pkg::ROWS; row++) begin
        for (int col = 0; col < adaptive_bin_pkg::COLS; col++) begin
          drive_pixel(img, col, row);
          if (img == 1) begin  // Idle gaps on the random image
            lcg_state = lcg_next(lcg_state);
            gap = int'(lcg_state[31:30]);
            repeat (gap) step_idle();
          end
        end
      end
    end
    step_idle();
    while (exp_q.size() != 0) @(posedge clk);
    repeat (2 * LATENCY) @(posedge clk);
    for (int img = 0; img < NUM_IMAGES; img++) begin
      if (img_count[img] != IMG_RES) begin
        $display("Image %0d gave %0d results instead of %0d", img, img_count[img], IMG_RES);
        flow_errors++;
      end
    end
    $display("Run done: %0d value errors, %0d missing, extra or count errors",
             value_errors, flow_errors);
    if (value_errors == 0 && flow_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, results still pending", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
